/* design/cache_geom_pkg.sv */
//==============================
// Cache geometry constants and
// address field widths
//==============================
`default_nettype none

package cache_geom_pkg;

  //==============================
  // Core word and address
  //==============================
  localparam int addr_w = 32;
  localparam int word_w = 32;

  //==============================
  // Line layout
  //==============================
  localparam int line_words     = 4;
  localparam int bytes_per_line = 16;
  localparam int line_w         = line_words * word_w;  // 128

  // Address split is tag | index | offset
  localparam int offset_w  = 4;
  localparam int index_w   = 6;
  localparam int tag_w     = addr_w - index_w - offset_w;  // 22
  localparam int num_lines = 64;

endpackage : cache_geom_pkg

`default_nettype wire

/* design/cache_access_pkg.sv */
//==============================
// Access sizes, FSM states and
// the word type
//==============================
`default_nettype none

package cache_access_pkg;

  typedef logic [cache_geom_pkg::word_w-1:0] word_t;

  // Same codes as core_type and D_type
  typedef enum logic [2:0] {
    size_byte = 3'b000,
    size_half = 3'b001,
    size_word = 3'b010
  } access_size_e;

  // Lookup controller
  typedef enum logic [1:0] {
    lk_idle    = 2'd0,
    lk_compare = 2'd1,
    lk_refill  = 2'd2,
    lk_store   = 2'd3
  } lookup_state_e;

  // Memory port sequencer
  typedef enum logic [1:0] {
    mp_idle  = 2'd0,
    mp_fill  = 2'd1,
    mp_store = 2'd2
  } mem_state_e;

  localparam int fill_beats = 4;  // Words per refill

endpackage : cache_access_pkg

`default_nettype wire

/* design/l1d_lookup.sv */
//==============================
// Lookup controller: core side,
// hit check, refill and store
//==============================
`default_nettype none
`timescale 1ns/100ps

module l1d_lookup (
  input  logic                                      clk,
  input  logic                                      rst,
  input  logic                                      core_req,
  input  logic                                      core_write,
  input  logic [cache_geom_pkg::addr_w-1:0]         core_addr,
  input  cache_access_pkg::word_t                   core_in,
  input  cache_access_pkg::access_size_e            core_type,
  input  logic                                      rd_valid,
  input  logic [cache_geom_pkg::tag_w-1:0]          rd_tag,
  input  logic [cache_geom_pkg::line_w-1:0]         rd_line,
  input  logic                                      fill_done,
  input  logic                                      store_done,
  output cache_access_pkg::word_t                   core_out,
  output logic                                      core_wait,
  output logic [cache_geom_pkg::index_w-1:0]        index,
  output logic [cache_geom_pkg::tag_w-1:0]          tag,
  output logic                                      st_we,
  output logic [cache_geom_pkg::bytes_per_line-1:0] st_mask,
  output logic [cache_geom_pkg::line_w-1:0]         st_data,
  output logic                                      fill_start,
  output logic                                      store_start,
  output logic [cache_geom_pkg::addr_w-1:0]         req_addr,
  output cache_access_pkg::word_t                   req_data,
  output cache_access_pkg::access_size_e            req_size
);

  cache_access_pkg::lookup_state_e state, state_next;
  logic                            req_write;
  logic                            hit;
  logic                            done;
  logic [$clog2(cache_geom_pkg::line_words)-1:0] word_sel;
  logic [3:0]                      lane_mask;
  cache_access_pkg::word_t         lane_data;

  //==============================
  // Request latch
  //==============================
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state     <= cache_access_pkg::lk_idle;
      req_write <= 1'b0;
    end
    else
    begin
      state <= state_next;
      if (state == cache_access_pkg::lk_idle && core_req)
        req_write <= core_write;
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == cache_access_pkg::lk_idle && core_req)
    begin
      req_addr <= core_addr;
      req_data <= core_in;
      req_size <= core_type;
    end
  end

  // Idle presents the incoming index so the arrays answer in compare
  assign index = (state == cache_access_pkg::lk_idle) ?
                 core_addr[cache_geom_pkg::offset_w +: cache_geom_pkg::index_w] :
                 req_addr[cache_geom_pkg::offset_w +: cache_geom_pkg::index_w];
  assign tag   = req_addr[cache_geom_pkg::addr_w-1 -: cache_geom_pkg::tag_w];

  assign hit      = rd_valid && (rd_tag == tag);
  assign word_sel = req_addr[cache_geom_pkg::offset_w-1:2];
  assign core_out = rd_line[word_sel*cache_geom_pkg::word_w +: cache_geom_pkg::word_w];

  // Read hit in compare, or store acknowledged by the memory port
  assign done = (state == cache_access_pkg::lk_compare && !req_write && hit) ||
                (state == cache_access_pkg::lk_store && store_done);
  assign core_wait = core_req && !done;

  assign fill_start  = (state == cache_access_pkg::lk_compare) && !req_write && !hit;
  assign store_start = (state == cache_access_pkg::lk_compare) && req_write;
  assign st_we       = store_start && hit;  // No allocate on store miss

  //==============================
  // Store byte lanes
  //==============================
  always_comb
  begin
    case (req_size)
      cache_access_pkg::size_byte:
      begin
        lane_mask = 4'b0001 << req_addr[1:0];
        lane_data = {4{req_data[7:0]}};
      end
      cache_access_pkg::size_half:
      begin
        lane_mask = req_addr[1] ? 4'b1100 : 4'b0011;
        lane_data = {2{req_data[15:0]}};
      end
      default:
      begin
        lane_mask = 4'b1111;
        lane_data = req_data;
      end
    endcase
  end

  assign st_mask = {12'd0, lane_mask} << {word_sel, 2'b00};
  assign st_data = {cache_geom_pkg::line_words{lane_data}};  // Mask picks the word

  always_comb
  begin
    state_next = state;
    case (state)
      cache_access_pkg::lk_idle:
        if (core_req)
          state_next = cache_access_pkg::lk_compare;
      cache_access_pkg::lk_compare:
      begin
        if (req_write)
          state_next = cache_access_pkg::lk_store;
        else if (hit)
          state_next = cache_access_pkg::lk_idle;
        else
          state_next = cache_access_pkg::lk_refill;
      end
      cache_access_pkg::lk_refill:
        if (fill_done)
          state_next = cache_access_pkg::lk_compare;  // Replay as hit
      cache_access_pkg::lk_store:
        if (store_done)
          state_next = cache_access_pkg::lk_idle;
      default:
        state_next = cache_access_pkg::lk_idle;
    endcase
  end

endmodule : l1d_lookup

`default_nettype wire

/* design/l1d_line_store.sv */
//==============================
// Valid, tag and data arrays
//==============================
`default_nettype none
`timescale 1ns/100ps

module l1d_line_store (
  input  logic                                      clk,
  input  logic                                      rst,
  input  logic [cache_geom_pkg::index_w-1:0]        index,
  input  logic [cache_geom_pkg::tag_w-1:0]          tag,
  input  logic                                      st_we,
  input  logic [cache_geom_pkg::bytes_per_line-1:0] st_mask,
  input  logic [cache_geom_pkg::line_w-1:0]         st_data,
  input  logic                                      fill_we,
  input  logic [cache_geom_pkg::line_w-1:0]         fill_line,
  output logic                                      rd_valid,
  output logic [cache_geom_pkg::tag_w-1:0]          rd_tag,
  output logic [cache_geom_pkg::line_w-1:0]         rd_line
);

  logic [cache_geom_pkg::num_lines-1:0] valid_q;
  logic [cache_geom_pkg::tag_w-1:0]     tag_q  [cache_geom_pkg::num_lines];
  logic [cache_geom_pkg::line_w-1:0]    data_q [cache_geom_pkg::num_lines];

  //==============================
  // Valid bits
  //==============================
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      valid_q  <= '0;
      rd_valid <= 1'b0;
    end
    else
    begin
      if (fill_we)
        valid_q[index] <= 1'b1;
      rd_valid <= fill_we ? 1'b1 : valid_q[index];
    end
  end

  //==============================
  // Tag and data
  //==============================
  always_ff @(posedge clk)
  begin
    if (fill_we)
    begin
      tag_q[index]  <= tag;
      data_q[index] <= fill_line;
    end
    else if (st_we)
    begin
      for (int b = 0; b < cache_geom_pkg::bytes_per_line; b++)
      begin
        if (st_mask[b])
          data_q[index][8*b +: 8] <= st_data[8*b +: 8];
      end
    end
  end

  // Fresh fill goes straight to the read port for the replay
  always_ff @(posedge clk)
  begin
    rd_tag  <= fill_we ? tag : tag_q[index];
    rd_line <= fill_we ? fill_line : data_q[index];
  end

endmodule : l1d_line_store

`default_nettype wire

/* design/l1d_mem_port.sv */
//==============================
// Memory sequencer for refill
// and write-through beats
//==============================
`default_nettype none
`timescale 1ns/100ps

module l1d_mem_port (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              fill_start,
  input  logic                              store_start,
  input  logic [cache_geom_pkg::addr_w-1:0] req_addr,
  input  cache_access_pkg::word_t           req_data,
  input  cache_access_pkg::access_size_e    req_size,
  input  cache_access_pkg::word_t           D_out,
  input  logic                              D_wait,
  output logic                              fill_we,
  output logic [cache_geom_pkg::line_w-1:0] fill_line,
  output logic                              fill_done,
  output logic                              store_done,
  output logic                              D_req,
  output logic                              D_write,
  output logic [cache_geom_pkg::addr_w-1:0] D_addr,
  output cache_access_pkg::word_t           D_in,
  output cache_access_pkg::access_size_e    D_type
);

  localparam int beat_w = $clog2(cache_access_pkg::fill_beats);

  cache_access_pkg::mem_state_e state;
  logic [beat_w-1:0]            beat;
  logic                         beat_end;
  logic                         last_beat;

  assign beat_end  = D_req && !D_wait;
  assign last_beat = (beat == beat_w'(cache_access_pkg::fill_beats - 1));

  //==============================
  // Sequencer
  //==============================
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state      <= cache_access_pkg::mp_idle;
      beat       <= '0;
      fill_we    <= 1'b0;
      fill_done  <= 1'b0;
      store_done <= 1'b0;
    end
    else
    begin
      fill_we    <= 1'b0;
      fill_done  <= 1'b0;
      store_done <= 1'b0;
      case (state)
        cache_access_pkg::mp_idle:
        begin
          beat <= '0;
          if (fill_start)
            state <= cache_access_pkg::mp_fill;
          else if (store_start)
            state <= cache_access_pkg::mp_store;
        end
        cache_access_pkg::mp_fill:
          if (beat_end)
          begin
            beat <= beat + 1'b1;
            if (last_beat)
            begin
              state     <= cache_access_pkg::mp_idle;
              fill_we   <= 1'b1;  // Line complete next cycle
              fill_done <= 1'b1;
            end
          end
        cache_access_pkg::mp_store:
          if (beat_end)
          begin
            state      <= cache_access_pkg::mp_idle;
            store_done <= 1'b1;
          end
        default:
          state <= cache_access_pkg::mp_idle;
      endcase
    end
  end

  // Collect refill words by beat
  always_ff @(posedge clk)
  begin
    if (state == cache_access_pkg::mp_fill && beat_end)
      fill_line[beat*cache_geom_pkg::word_w +: cache_geom_pkg::word_w] <= D_out;
  end

  //==============================
  // Memory pins
  //==============================
  assign D_req   = (state == cache_access_pkg::mp_fill) ||
                   (state == cache_access_pkg::mp_store);
  assign D_write = (state == cache_access_pkg::mp_store);
  assign D_addr  = (state == cache_access_pkg::mp_fill) ?
                   {req_addr[cache_geom_pkg::addr_w-1:cache_geom_pkg::offset_w], beat, 2'b00} :
                   req_addr;
  assign D_in    = req_data;  // Unshifted, memory applies the lanes
  assign D_type  = (state == cache_access_pkg::mp_store) ? req_size :
                   cache_access_pkg::size_word;

endmodule : l1d_mem_port

`default_nettype wire

/* design/l1d_cache.sv */
//==============================
// L1 data cache top level
//==============================
`default_nettype none
`timescale 1ns/100ps

module l1d_cache (
  input  logic                              clk,
  input  logic                              rst,
  // Core side
  input  logic                              core_req,
  input  logic                              core_write,
  input  logic [cache_geom_pkg::addr_w-1:0] core_addr,
  input  cache_access_pkg::word_t           core_in,
  input  cache_access_pkg::access_size_e    core_type,
  output cache_access_pkg::word_t           core_out,
  output logic                              core_wait,
  // Memory side
  output logic                              D_req,
  output logic                              D_write,
  output logic [cache_geom_pkg::addr_w-1:0] D_addr,
  output cache_access_pkg::word_t           D_in,
  output cache_access_pkg::access_size_e    D_type,
  input  cache_access_pkg::word_t           D_out,
  input  logic                              D_wait
);

  logic [cache_geom_pkg::index_w-1:0]        index;
  logic [cache_geom_pkg::tag_w-1:0]          tag;
  logic                                      st_we;
  logic [cache_geom_pkg::bytes_per_line-1:0] st_mask;
  logic [cache_geom_pkg::line_w-1:0]         st_data;
  logic                                      fill_start;
  logic                                      store_start;
  logic [cache_geom_pkg::addr_w-1:0]         req_addr;
  cache_access_pkg::word_t                   req_data;
  cache_access_pkg::access_size_e            req_size;
  logic                                      fill_we;
  logic [cache_geom_pkg::line_w-1:0]         fill_line;
  logic                                      fill_done;
  logic                                      store_done;
  logic                                      rd_valid;
  logic [cache_geom_pkg::tag_w-1:0]          rd_tag;
  logic [cache_geom_pkg::line_w-1:0]         rd_line;

  l1d_lookup u_lookup (
    .clk, .rst,
    .core_req, .core_write, .core_addr, .core_in, .core_type,
    .rd_valid, .rd_tag, .rd_line,
    .fill_done, .store_done,
    .core_out, .core_wait,
    .index, .tag, .st_we, .st_mask, .st_data,
    .fill_start, .store_start, .req_addr, .req_data, .req_size
  );

  l1d_line_store u_line_store (
    .clk, .rst,
    .index, .tag, .st_we, .st_mask, .st_data,
    .fill_we, .fill_line,
    .rd_valid, .rd_tag, .rd_line
  );

  l1d_mem_port u_mem_port (
    .clk, .rst,
    .fill_start, .store_start, .req_addr, .req_data, .req_size,
    .D_out, .D_wait,
    .fill_we, .fill_line, .fill_done, .store_done,
    .D_req, .D_write, .D_addr, .D_in, .D_type
  );

endmodule : l1d_cache

`default_nettype wire

/* dv/l1d_mem_model.sv */
//==============================
// Word memory model with random
// wait states and beat counters
//==============================
`default_nettype none
`timescale 1ns/100ps

module l1d_mem_model #(
  parameter int depth = 1024
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              D_req,
  input  logic                              D_write,
  input  logic [cache_geom_pkg::addr_w-1:0] D_addr,
  input  cache_access_pkg::word_t           D_in,
  input  cache_access_pkg::access_size_e    D_type,
  output cache_access_pkg::word_t           D_out,
  output logic                              D_wait,
  output int                                read_beats,
  output int                                write_beats
);

  localparam int aw = $clog2(depth);

  cache_access_pkg::word_t mem [depth];
  logic [aw-1:0]           waddr;
  logic [1:0]              wait_left;  // Wait cycles left in this beat

  assign waddr  = D_addr[aw+1:2];
  assign D_out  = mem[waddr];
  assign D_wait = D_req && (wait_left != 2'd0);

  initial
  begin
    for (int i = 0; i < depth; i++)
      mem[i] = 32'(i) ^ 32'h5a5a0000;
  end

  //==============================
  // Beat completion
  //==============================
  always @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wait_left   <= 2'd0;
      read_beats  <= 0;
      write_beats <= 0;
    end
    else if (D_req)
    begin
      if (wait_left != 2'd0)
        wait_left <= wait_left - 2'd1;
      else
      begin
        wait_left <= 2'($urandom % 4);  // Drawn for the next beat
        if (D_write)
        begin
          write_beats <= write_beats + 1;
          case (D_type)
            cache_access_pkg::size_byte: mem[waddr][8*D_addr[1:0] +: 8] <= D_in[7:0];
            cache_access_pkg::size_half: mem[waddr][16*D_addr[1] +: 16] <= D_in[15:0];
            default:                     mem[waddr] <= D_in;
          endcase
        end
        else
          read_beats <= read_beats + 1;
      end
    end
  end

endmodule : l1d_mem_model

`default_nettype wire

/* dv/l1d_cache_tb.sv */
//==============================
// Cache testbench with directed
// tests, beat monitor and report
//==============================
`default_nettype none
`timescale 1ns/100ps

module l1d_cache_tb;

  localparam int mem_depth      = 1024;
  localparam int mem_aw         = $clog2(mem_depth);
  localparam int access_timeout = 200;  // Cycles per access

  logic                              clk;
  logic                              rst;
  logic                              core_req;
  logic                              core_write;
  logic [cache_geom_pkg::addr_w-1:0] core_addr;
  cache_access_pkg::word_t           core_in;
  cache_access_pkg::access_size_e    core_type;
  cache_access_pkg::word_t           core_out;
  logic                              core_wait;
  logic                              D_req;
  logic                              D_write;
  logic [cache_geom_pkg::addr_w-1:0] D_addr;
  cache_access_pkg::word_t           D_in;
  cache_access_pkg::access_size_e    D_type;
  cache_access_pkg::word_t           D_out;
  logic                              D_wait;
  int                                read_beats;
  int                                write_beats;
  int                                errors;
  bit                                aborted;

  cache_access_pkg::word_t           ref_mem [mem_depth];  // Expected memory
  logic [cache_geom_pkg::addr_w-1:0] beat_addr [$];
  cache_access_pkg::access_size_e    beat_type [$];
  logic                              beat_write [$];
  cache_access_pkg::word_t           beat_data [$];

  l1d_cache u_l1d_cache (
    .clk, .rst,
    .core_req, .core_write, .core_addr, .core_in, .core_type, .core_out, .core_wait,
    .D_req, .D_write, .D_addr, .D_in, .D_type, .D_out, .D_wait
  );

  l1d_mem_model #(.depth(mem_depth)) u_mem_model (
    .clk, .rst,
    .D_req, .D_write, .D_addr, .D_in, .D_type, .D_out, .D_wait,
    .read_beats, .write_beats
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // A beat seen here completes at the next rising edge
  always @(negedge clk)
  begin
    if (!rst && D_req && !D_wait)
    begin
      beat_addr.push_back(D_addr);
      beat_type.push_back(D_type);
      beat_write.push_back(D_write);
      beat_data.push_back(D_in);
    end
  end

  //==============================
  // Helpers
  //==============================
  function automatic cache_access_pkg::word_t initial_word(input int i);
    return 32'(i) ^ 32'h5a5a0000;
  endfunction

  function automatic cache_access_pkg::word_t merge_lanes(
    input cache_access_pkg::word_t old, input cache_access_pkg::word_t data,
    input logic [1:0] lane, input cache_access_pkg::access_size_e size);
    cache_access_pkg::word_t w;
    w = old;
    case (size)
      cache_access_pkg::size_byte: w[8*lane +: 8] = data[7:0];
      cache_access_pkg::size_half: w[16*lane[1] +: 16] = data[15:0];
      default:                     w = data;
    endcase
    return w;
  endfunction

  task automatic compare_value(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (!aborted && expected !== actual)
    begin
      errors++;
      $display("error %s: expected %h actual %h", test, expected, actual);
    end
  endtask

  task automatic core_access(input logic wr, input logic [31:0] addr,
                             input cache_access_pkg::word_t data,
                             input cache_access_pkg::access_size_e size,
                             output cache_access_pkg::word_t rdata, output int waits);
    int n;
    rdata = '0;
    waits = 0;
    n     = 0;
    if (aborted)
      return;
    beat_addr.delete();
    beat_type.delete();
    beat_write.delete();
    beat_data.delete();
    @(posedge clk);
    core_req   <= 1'b1;
    core_write <= wr;
    core_addr  <= addr;
    core_in    <= data;
    core_type  <= size;
    @(negedge clk);
    while (core_wait && n < access_timeout)
    begin
      n++;
      @(negedge clk);
    end
    if (core_wait)
    begin
      aborted = 1'b1;
      errors++;
      $display("timeout: the cache never finished the access to address %h", addr);
    end
    rdata = core_out;
    waits = n;
    @(posedge clk);
    core_req <= 1'b0;
  endtask

  task automatic load_and_check(input string test, input logic [31:0] addr,
                                input int exp_beats);
    cache_access_pkg::word_t rdata;
    int                      waits;
    core_access(1'b0, addr, '0, cache_access_pkg::size_word, rdata, waits);
    compare_value({test, " data"}, ref_mem[addr[mem_aw+1:2]], rdata);
    compare_value({test, " beat count"}, exp_beats, beat_addr.size());
    if (exp_beats == 0)
      compare_value({test, " hit wait cycles"}, 1, waits);
  endtask

  task automatic store_and_check(input string test, input logic [31:0] addr,
                                 input cache_access_pkg::word_t data,
                                 input cache_access_pkg::access_size_e size);
    cache_access_pkg::word_t rdata;
    int                      waits;
    core_access(1'b1, addr, data, size, rdata, waits);
    ref_mem[addr[mem_aw+1:2]] = merge_lanes(ref_mem[addr[mem_aw+1:2]], data, addr[1:0], size);
    compare_value({test, " beat count"}, 1, beat_addr.size());
    if (beat_addr.size() == 1)
    begin
      compare_value({test, " beat address"}, addr, beat_addr[0]);
      compare_value({test, " beat write"}, 1, beat_write[0]);
      compare_value({test, " beat size"}, 32'(size), 32'(beat_type[0]));
      compare_value({test, " beat data"}, data, beat_data[0]);
    end
  endtask

  task automatic refill_order(input string test, input logic [31:0] base);
    for (int i = 0; i < beat_addr.size() && i < 4; i++)
    begin
      compare_value({test, " refill address"}, base + 4*i, beat_addr[i]);
      compare_value({test, " refill write"}, 0, beat_write[i]);
    end
  endtask

  //==============================
  // Directed tests
  //==============================
  task automatic reset_then_miss;
    @(negedge clk);
    compare_value("reset_then_miss core_wait", 0, core_wait);
    compare_value("reset_then_miss D_req", 0, D_req);
    load_and_check("reset_then_miss", 32'h108, 4);
  endtask

  task automatic refill_beat_order;
    compare_value("refill_beat_order beats", 4, beat_addr.size());
    refill_order("refill_beat_order", 32'h100);
  endtask

  task automatic repeat_hits;
    for (int w = 0; w < 4; w++)
      load_and_check("repeat_hits", 32'h100 + 4*w, 0);
  endtask

  task automatic stores_to_cached_line;
    store_and_check("byte store hit", 32'h101, 32'h000000a5, cache_access_pkg::size_byte);
    store_and_check("half store hit", 32'h106, 32'h0000beef, cache_access_pkg::size_half);
    store_and_check("word store hit", 32'h10c, 32'h12345678, cache_access_pkg::size_word);
    for (int w = 0; w < 4; w++)
      load_and_check("stores_to_cached_line", 32'h100 + 4*w, 0);
  endtask

  task automatic store_without_allocate;
    store_and_check("store_without_allocate", 32'h20a, 32'h1234cafe,
                    cache_access_pkg::size_half);
    load_and_check("store_without_allocate", 32'h208, 4);
    refill_order("store_without_allocate", 32'h200);
  endtask

  task automatic same_index_eviction;
    for (int r = 0; r < 2; r++)
    begin
      load_and_check("same_index_eviction low tag", 32'h044, 4);
      refill_order("same_index_eviction low tag", 32'h040);
      load_and_check("same_index_eviction high tag", 32'h444, 4);
      refill_order("same_index_eviction high tag", 32'h440);
    end
  endtask

  initial
  begin
    void'($urandom(80));
    errors     = 0;
    aborted    = 1'b0;
    rst        = 1'b1;
    core_req   = 1'b0;
    core_write = 1'b0;
    core_addr  = '0;
    core_in    = '0;
    core_type  = cache_access_pkg::size_word;
    for (int i = 0; i < mem_depth; i++)
      ref_mem[i] = initial_word(i);
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    reset_then_miss();
    refill_beat_order();
    repeat_hits();
    stores_to_cached_line();
    store_without_allocate();
    same_index_eviction();
    @(negedge clk);
    $display("errors %0d, memory read beats %0d, memory write beats %0d",
             errors, read_beats, write_beats);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule : l1d_cache_tb

`default_nettype wire

/* l1d_cache.f */
design/cache_geom_pkg.sv
design/cache_access_pkg.sv
design/l1d_lookup.sv
design/l1d_line_store.sv
design/l1d_mem_port.sv
design/l1d_cache.sv
dv/l1d_mem_model.sv
dv/l1d_cache_tb.sv

/* Makefile */
# Verilator build and run for the L1 data cache

VERILATOR  ?= verilator
TOP        := l1d_cache_tb
RTL_TOP    := l1d_cache
FILELIST   := l1d_cache.f
FLAGS      := --binary --timing --timescale 1ns/100ps -j 0
LINT_FLAGS := --lint-only --timing --timescale 1ns/100ps
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)

# Pass or fail comes from the log
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
